/* verilog.f */
+incdir+.
cdb_pkg.sv
divsqrt_pkg.sv
issue_router.sv
divsqrt_core.sv
divsqrt_station.sv
cdb_arbiter.sv
divsqrt_top.sv
divsqrt_assert.sv
divsqrt_tb.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f verilog.f --top-module divsqrt_tb -Mdir obj_dir

run: compile
	out="$$(./obj_dir/Vdivsqrt_tb)"; echo "$$out"; \
	echo "$$out" | grep -q "^PASS: all tests$$"

clean:
	rm -rf obj_dir

/* divsqrt_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rs_settings.svh"

module divsqrt_tb
	import cdb_pkg::*, divsqrt_pkg::*;
();

	localparam int N_ROWS = 20;
	localparam int LIMIT  = 60 * N_ROWS + 200;

	typedef struct {
		logic        op;  // 1 for square root.
		logic [31:0] a;
		logic [31:0] b;
		bit          pa;
		int          da;
		bit          pb;
		int          db;
	} row_t;

	typedef struct {
		int          due;
		logic [5:0]  tag;
		logic [31:0] data;
	} cdb_event_t;

	logic    clk;
	logic    reset;
	logic    issue_valid;
	issue_t  issue;
	logic    issue_ready;
	cdb_t    cdb_in;
	logic    result_valid;
	result_t result;
	logic    result_ready;

	row_t         rows [N_ROWS];
	cdb_event_t   events [$];
	logic [31:0]  exp_data [int];
	cdb_t         zero_cdb;
	int           cyc;
	int           received;
	int           next_ptag;
	bit           hold_low;
	bit           saw_full;
	logic [31:0]  rng;

	divsqrt_top uut (
		.clk          (clk),
		.reset        (reset),
		.issue_valid  (issue_valid),
		.issue        (issue),
		.issue_ready  (issue_ready),
		.cdb_in       (cdb_in),
		.result_valid (result_valid),
		.result       (result),
		.result_ready (result_ready)
	);

	bind divsqrt_top divsqrt_assert u_assert (
		.clk          (clk),
		.reset        (reset),
		.issue_valid  (issue_valid),
		.issue_ready  (issue_ready),
		.entry_valid  (entry_valid),
		.result_valid (result_valid),
		.result       (result),
		.result_ready (result_ready)
	);

	always #20 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] expected_div(input logic [31:0] a, input logic [31:0] b);
		if (b == 32'd0) begin
			return 32'hffff_ffff;
		end
		return a / b;
	endfunction

	// largest r with r*r <= a, found one bit at a time from the top.
	function automatic logic [31:0] expected_sqrt(input logic [31:0] a);
		logic [63:0] r;
		logic [63:0] t;
		r = 64'd0;
		for (int i = 15; i >= 0; i--) begin
			t = r | (64'd1 << i);
			if (t * t <= {32'd0, a}) begin
				r = t;
			end
		end
		return r[31:0];
	endfunction

	task automatic set_row(input int i, input logic op, input logic [31:0] a,
		input logic [31:0] b, input bit pa, input int da, input bit pb, input int db);
		rows[i] = '{op, a, b, pa, da, pb, db};
	endtask

	task automatic stop_on_error();
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic fill_table();
		set_row(0, 1'b0, 32'd100, 32'd7, 0, 0, 0, 0);
		set_row(1, 1'b0, 32'hffff_ffff, 32'd1, 0, 0, 0, 0);
		set_row(2, 1'b0, 32'd12345, 32'd0, 0, 0, 0, 0);  // zero divisor.
		set_row(3, 1'b1, 32'd0, 32'h5a5a_5a5a, 0, 0, 0, 0);
		set_row(4, 1'b1, 32'd1, 32'h0000_0033, 0, 0, 0, 0);
		set_row(5, 1'b1, 32'hffff_ffff, 32'hffff_ffff, 0, 0, 0, 0);
		set_row(6, 1'b0, 32'd1000, 32'd33, 1, 0, 0, 0);
		set_row(7, 1'b0, 32'd77, 32'd0, 0, 0, 1, 3);
		set_row(8, 1'b1, 32'd99, 32'h1234_0000, 1, 0, 0, 0);
		set_row(9, 1'b1, 32'd144, 32'd0, 1, 5, 0, 0);
		set_row(10, 1'b0, 32'h8000_0000, 32'd3, 1, 2, 1, 0);
		set_row(11, 1'b0, 32'd5, 32'd9, 0, 0, 0, 0);
		set_row(12, 1'b1, 32'h4000_0000, 32'd7, 0, 0, 0, 0);
		set_row(13, 1'b0, 32'hdead_beef, 32'h0000_1234, 1, 1, 1, 1);
		set_row(14, 1'b1, 32'd2, 32'd0, 1, 4, 0, 0);
		set_row(15, 1'b0, 32'd999999, 32'd999999, 0, 0, 1, 0);
		set_row(16, 1'b1, 32'h1234_5678, 32'd1, 1, 1, 0, 0);
		set_row(17, 1'b0, 32'd65536, 32'd256, 1, 6, 1, 2);
		set_row(18, 1'b1, 32'd15, 32'hdead_0000, 0, 0, 1, 0);  // b pending and never sent.
		set_row(19, 1'b0, 32'h7fff_ffff, 32'd2, 1, 0, 0, 0);
	endtask

	// cycle count and run limit.
	always @(posedge clk) begin
		if (cyc >= LIMIT) begin
			$display("timeout after %0d cycles with %0d of %0d results", cyc, received, N_ROWS);
			stop_on_error();
		end else begin
			cyc <= cyc + 1;
		end
	end

	always @(posedge clk) begin
		rng = xorshift(rng);
		result_ready <= hold_low ? 1'b0 : (rng % 3 != 0);
	end

	// cdb driver for producers that are not in the register file.
	always @(posedge clk) begin
		int pick;
		pick = -1;
		if (zero_cdb.valid) begin
			cdb_in <= zero_cdb;  // held until the issue is taken.
		end else begin
			for (int k = events.size() - 1; k >= 0; k--) begin
				if (events[k].due <= cyc) begin
					pick = k;
				end
			end
			if (pick >= 0) begin
				cdb_in <= '{1'b1, events[pick].tag, events[pick].data};
				events.delete(pick);
			end else begin
				cdb_in.valid <= 1'b0;
			end
		end
	end

	// result checks and the full-cluster release.
	always @(negedge clk) begin
		int t;
		if (!reset) begin
			if (hold_low && issue_valid && !issue_ready) begin
				saw_full = 1'b1;
				hold_low = 1'b0;
			end
			if (result_valid && result_ready) begin
				t = int'(result.tag);
				assert (exp_data.exists(t)) else begin
					$display("result tag %h was never issued or came back twice", result.tag);
					stop_on_error();
				end
				assert (result.data == exp_data[t]) else begin
					$display("mismatch result.data tag %h: got %h expected %h",
						result.tag, result.data, exp_data[t]);
					stop_on_error();
				end
				exp_data.delete(t);
				received++;
			end
		end
	end

	function automatic cdb_t make_opd(input bit pend, input logic [31:0] v);
		cdb_t o;
		o.valid = !pend;
		o.tag   = pend ? 6'(32 + (next_ptag % 32)) : 6'd0;
		o.data  = pend ? 32'hbad0_bad0 : v;
		return o;
	endfunction

	initial begin
		issue_t     cur;
		row_t       r;
		cdb_event_t ev;
		int         c;
		clk          = 1'b0;
		reset        = 1'b1;
		issue_valid  = 1'b0;
		issue        = '0;
		cdb_in       = '0;
		result_ready = 1'b0;
		zero_cdb     = '0;
		cyc          = 0;
		received     = 0;
		next_ptag    = 0;
		hold_low     = 1'b1;  // results held until the cluster fills.
		saw_full     = 1'b0;
		rng          = 32'd69;
		fill_table();

		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		assert (!result_valid) else begin
			$display("mismatch result_valid after reset: got %h expected %h", result_valid, 1'b0);
			stop_on_error();
		end
		assert (issue_ready) else begin
			$display("mismatch issue_ready after reset: got %h expected %h", issue_ready, 1'b1);
			stop_on_error();
		end

		for (int i = 0; i < N_ROWS; i++) begin
			@(negedge clk);
			r          = rows[i];
			cur.tag    = 6'(i);
			cur.op     = r.op ? OP_SQRT : OP_DIV;
			cur.opd[0] = make_opd(r.pa, r.a);
			if (r.pa) begin
				next_ptag++;
			end
			cur.opd[1] = make_opd(r.pb, r.b);
			if (r.pb) begin
				next_ptag++;
			end
			// the second operand of a square root is never broadcast.
			zero_cdb = '0;
			if (r.pa && r.da == 0) begin
				zero_cdb = '{1'b1, cur.opd[0].tag, r.a};
			end
			if (r.pb && r.db == 0 && !r.op) begin
				zero_cdb = '{1'b1, cur.opd[1].tag, r.b};
			end
			@(posedge clk);
			issue_valid <= 1'b1;
			issue       <= cur;
			do begin
				@(negedge clk);
			end while (!issue_ready);
			c = cyc;  // the next edge takes the issue.
			if (r.pa && r.da > 0) begin
				ev = '{c + r.da - 1, cur.opd[0].tag, r.a};
				events.push_back(ev);
			end
			if (r.pb && r.db > 0 && !r.op) begin
				ev = '{c + r.db - 1, cur.opd[1].tag, r.b};
				events.push_back(ev);
			end
			exp_data[i] = r.op ? expected_sqrt(r.a) : expected_div(r.a, r.b);
			@(posedge clk);
			issue_valid <= 1'b0;
		end
		@(negedge clk);
		zero_cdb = '0;
		hold_low = 1'b0;

		while (received < N_ROWS) begin
			@(negedge clk);
		end
		assert (saw_full) else begin
			$display("issue_ready never fell while results were held back");
			stop_on_error();
		end

		// a core finishes within 32 cycles, so a stray result would show by now.
		repeat (40) @(negedge clk);
		assert (!result_valid) else begin
			$display("a result appeared after every issued tag had returned");
			stop_on_error();
		end
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

/* divsqrt_assert.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rs_settings.svh"

module divsqrt_assert
	import cdb_pkg::*;
(
	input wire logic                   clk,
	input wire logic                   reset,
	input wire logic                   issue_valid,
	input wire logic                   issue_ready,
	input wire logic [`RS_N_UNITS-1:0] entry_valid,
	input wire logic                   result_valid,
	input wire result_t                result,
	input wire logic                   result_ready
);

	// a held result must not move until the sink takes it.
	result_hold: assert property (@(posedge clk) disable iff (reset)
		result_valid && !result_ready |=> result_valid && $stable(result))
		else $error("result_valid or result changed while result_ready was low");

	// a transfer writes exactly one station, and nothing is written without one.
	one_write_per_transfer: assert property (@(posedge clk) disable iff (reset)
		$onehot0(entry_valid) && ((|entry_valid) == (issue_valid && issue_ready)))
		else $error("station writes did not match the issue handshake");

	result_low_after_reset: assert property (@(posedge clk)
		$fell(reset) |-> !result_valid)
		else $error("result_valid high in the cycle after reset");

endmodule

`default_nettype wire

/* divsqrt_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rs_settings.svh"

module divsqrt_top
	import cdb_pkg::*, divsqrt_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    issue_valid,
	input  issue_t  issue,
	output logic    issue_ready,
	input  cdb_t    cdb_in,
	output logic    result_valid,
	output result_t result,
	input  logic    result_ready
);

	logic      [`RS_N_UNITS-1:0] accept_ok;
	logic      [`RS_N_UNITS-1:0] entry_valid;
	rs_entry_t                   entry;
	logic      [`RS_N_UNITS-1:0] done;
	logic      [`RS_N_UNITS-1:0] pop;
	result_t   [`RS_N_UNITS-1:0] unit_result;

	issue_router u_router (
		.clk         (clk),
		.reset       (reset),
		.issue_valid (issue_valid),
		.issue       (issue),
		.issue_ready (issue_ready),
		.cdb_in      (cdb_in),
		.accept_ok   (accept_ok),
		.entry_valid (entry_valid),
		.entry       (entry)
	);

	for (genvar u = 0; u < `RS_N_UNITS; u++) begin : g_unit
		divsqrt_station u_station (
			.clk         (clk),
			.reset       (reset),
			.entry_valid (entry_valid[u]),
			.entry       (entry),
			.accept_ok   (accept_ok[u]),
			.cdb_in      (cdb_in),
			.done        (done[u]),
			.result      (unit_result[u]),
			.pop         (pop[u])
		);
	end

	cdb_arbiter u_arbiter (
		.clk          (clk),
		.reset        (reset),
		.done         (done),
		.result_in    (unit_result),
		.pop          (pop),
		.result_valid (result_valid),
		.result       (result),
		.result_ready (result_ready)
	);

endmodule

`default_nettype wire

/* cdb_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rs_settings.svh"

module cdb_arbiter
	import cdb_pkg::*;
(
	input  logic                      clk,
	input  logic                      reset,
	input  logic    [`RS_N_UNITS-1:0] done,
	input  result_t [`RS_N_UNITS-1:0] result_in,
	output logic    [`RS_N_UNITS-1:0] pop,
	output logic                      result_valid,
	output result_t                   result,
	input  logic                      result_ready
);

	localparam int N  = `RS_N_UNITS;
	localparam int UW = (N > 1) ? $clog2(N) : 1;

	logic [UW-1:0] ptr;
	logic [UW-1:0] grant;
	logic          any;
	logic          load;

	// first finished unit at or after the pointer.
	always_comb begin
		int idx;
		grant = '0;
		any   = 1'b0;
		for (int k = N - 1; k >= 0; k--) begin
			idx = (int'(ptr) + k) % N;
			if (done[idx]) begin
				grant = UW'(idx);
				any   = 1'b1;
			end
		end
	end

	assign load = !result_valid || result_ready;

	always_comb begin
		pop = '0;
		if (load && any) begin
			pop[grant] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			result_valid <= 1'b0;
			ptr          <= '0;
		end else if (load) begin
			result_valid <= any;
			if (any) begin
				result <= result_in[grant];
				ptr    <= (int'(grant) == N - 1) ? '0 : grant + 1'b1;  // skip past the winner.
			end
		end
	end

endmodule

`default_nettype wire

/* divsqrt_station.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rs_settings.svh"

module divsqrt_station
	import cdb_pkg::*, divsqrt_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      entry_valid,
	input  rs_entry_t entry,
	output logic      accept_ok,
	input  cdb_t      cdb_in,
	output logic      done,
	output result_t   result,
	input  logic      pop
);

	localparam int N_ENTRY = `RS_N_ENTRY;
	localparam int SEL_W   = (N_ENTRY > 1) ? $clog2(N_ENTRY) : 1;

	rs_entry_t [N_ENTRY-1:0] e;  // packed from index 0, oldest first.
	rs_entry_t [N_ENTRY-1:0] e_upd;
	rs_entry_t [N_ENTRY-1:0] e_shift;
	rs_entry_t [N_ENTRY-1:0] e_next;
	logic      [N_ENTRY-1:0] ready;
	logic      [SEL_W-1:0]   sel;

	logic      req_valid;
	core_req_t req;
	logic      idle;
	logic      start;

	// cdb wakeup of waiting operands.
	always_comb begin
		for (int i = 0; i < N_ENTRY; i++) begin
			e_upd[i] = e[i];
			for (int j = 0; j < 2; j++) begin
				if (!e[i].opd[j].valid && tag_match(cdb_in, e[i].opd[j].tag)) begin
					e_upd[i].opd[j].valid = 1'b1;
					e_upd[i].opd[j].data  = cdb_in.data;
				end
			end
		end
	end

	// oldest entry with both operands present.
	always_comb begin
		for (int i = 0; i < N_ENTRY; i++) begin
			ready[i] = e[i].valid && e[i].opd[0].valid && e[i].opd[1].valid;
		end
		sel = '0;
		for (int i = N_ENTRY - 1; i >= 0; i--) begin
			if (ready[i]) begin
				sel = SEL_W'(i);
			end
		end
	end

	assign req_valid = |ready;
	assign req.tag   = e[sel].tag;
	assign req.op    = e[sel].op;
	assign req.a     = e[sel].opd[0].data;
	assign req.b     = e[sel].opd[1].data;
	assign start     = req_valid && idle;

	// remove the dispatched entry and close the gap.
	always_comb begin
		for (int i = 0; i < N_ENTRY - 1; i++) begin
			if (start && (i >= int'(sel))) begin
				e_shift[i] = e_upd[i + 1];
			end else begin
				e_shift[i] = e_upd[i];
			end
		end
		e_shift[N_ENTRY-1] = start ? '0 : e_upd[N_ENTRY-1];
	end

	// new entry lands in the first free slot after the shift.
	always_comb begin
		logic placed;
		placed = 1'b0;
		for (int i = 0; i < N_ENTRY; i++) begin
			e_next[i] = e_shift[i];
			if (entry_valid && !e_shift[i].valid && !placed) begin
				e_next[i]       = entry;
				e_next[i].valid = 1'b1;
				placed          = 1'b1;
			end
		end
	end

	assign accept_ok = !e[N_ENTRY-1].valid || start;

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < N_ENTRY; i++) begin
				e[i].valid <= 1'b0;
			end
		end else begin
			e <= e_next;
		end
	end

	divsqrt_core u_core (
		.clk       (clk),
		.reset     (reset),
		.req_valid (req_valid),
		.req       (req),
		.idle      (idle),
		.done      (done),
		.result    (result),
		.pop       (pop)
	);

endmodule

`default_nettype wire

/* divsqrt_core.sv */
`timescale 1ns/1ps
`default_nettype none

module divsqrt_core
	import cdb_pkg::*, divsqrt_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      req_valid,
	input  core_req_t req,
	output logic      idle,
	output logic      done,
	output result_t   result,
	input  logic      pop
);

	localparam int W   = $bits(word_t);
	localparam int CNT = $clog2(W);

	logic        busy;
	logic [CNT-1:0] count;
	divsqrt_op_t op;
	tag_t        tag;
	word_t       x;    // dividend or radicand, consumed from the top.
	word_t       d;
	word_t       rem;
	word_t       q;    // quotient or root, filled from the bottom.

	logic [W:0]   div_sh;
	logic [W+1:0] div_diff;
	logic         div_borrow;
	logic [W+1:0] sq_sh;
	logic [W+1:0] sq_trial;
	logic [W+1:0] sq_diff;
	logic         sq_borrow;

	assign div_sh     = {rem, x[W-1]};
	assign div_diff   = {1'b0, div_sh} - {2'b00, d};
	assign div_borrow = div_diff[W+1];  // a zero divisor never borrows, so q ends all ones.

	assign sq_sh     = {rem, x[W-1:W-2]};
	assign sq_trial  = {q, 2'b01};
	assign sq_diff   = sq_sh - sq_trial;
	assign sq_borrow = sq_diff[W+1];

	assign idle        = !busy && !done;
	assign result.tag  = tag;
	assign result.data = q;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			done <= 1'b0;
		end else if (busy) begin
			if (op == OP_DIV) begin
				rem <= div_borrow ? div_sh[W-1:0] : div_diff[W-1:0];
				q   <= {q[W-2:0], !div_borrow};
				x   <= {x[W-2:0], 1'b0};
			end else begin
				rem <= sq_borrow ? sq_sh[W-1:0] : sq_diff[W-1:0];
				q   <= {q[W-2:0], !sq_borrow};
				x   <= {x[W-3:0], 2'b00};
			end
			count <= count - 1'b1;
			if (count == '0) begin
				busy <= 1'b0;
				done <= 1'b1;
			end
		end else if (done) begin
			if (pop) begin
				done <= 1'b0;  // result held until the arbiter takes it.
			end
		end else if (req_valid) begin
			busy  <= 1'b1;
			op    <= req.op;
			tag   <= req.tag;
			x     <= req.a;
			d     <= req.b;
			rem   <= '0;
			q     <= '0;
			count <= (req.op == OP_DIV) ? CNT'(W - 1) : CNT'(W / 2 - 1);
		end
	end

endmodule

`default_nettype wire

/* issue_router.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rs_settings.svh"

module issue_router
	import cdb_pkg::*, divsqrt_pkg::*;
(
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   issue_valid,
	input  issue_t                 issue,
	output logic                   issue_ready,
	input  cdb_t                   cdb_in,
	input  logic [`RS_N_UNITS-1:0] accept_ok,
	output logic [`RS_N_UNITS-1:0] entry_valid,
	output rs_entry_t              entry
);

	// the register file is written one cycle after the broadcast,
	// so a read in that cycle can still report the operand as pending.
	cdb_t cdb_prev;

	always_ff @(posedge clk) begin
		if (reset) begin
			cdb_prev.valid <= 1'b0;
		end else begin
			cdb_prev <= cdb_in;
		end
	end

	always_comb begin
		entry.valid = issue_valid;
		entry.tag   = issue.tag;
		entry.op    = issue.op;
		for (int j = 0; j < 2; j++) begin
			entry.opd[j] = issue.opd[j];
			if (!issue.opd[j].valid) begin
				if (tag_match(cdb_in, issue.opd[j].tag)) begin
					entry.opd[j].valid = 1'b1;
					entry.opd[j].data  = cdb_in.data;  // same-cycle bypass.
				end else if (tag_match(cdb_prev, issue.opd[j].tag)) begin
					entry.opd[j].valid = 1'b1;
					entry.opd[j].data  = cdb_prev.data;
				end
			end
		end
		if (issue.op == OP_SQRT) begin
			entry.opd[1].valid = 1'b1;  // square root has no second operand.
		end
	end

	// lowest-numbered station with space takes the issue.
	always_comb begin
		logic found;
		found = 1'b0;
		for (int i = 0; i < `RS_N_UNITS; i++) begin
			entry_valid[i] = 1'b0;
			if (accept_ok[i] && !found) begin
				entry_valid[i] = issue_valid;
				found          = 1'b1;
			end
		end
	end

	assign issue_ready = |accept_ok;

endmodule

`default_nettype wire

/* divsqrt_pkg.sv */
`default_nettype none

package divsqrt_pkg;
	import cdb_pkg::*;

	typedef enum logic {
		OP_DIV  = 1'b0,
		OP_SQRT = 1'b1
	} divsqrt_op_t;

	typedef struct packed {
		tag_t        tag;
		divsqrt_op_t op;
		cdb_t [1:0]  opd;  // opd[0] is the dividend or radicand.
	} issue_t;

	// operand valid bit means the data has been captured.
	typedef struct packed {
		logic        valid;
		tag_t        tag;
		divsqrt_op_t op;
		cdb_t [1:0]  opd;
	} rs_entry_t;

	typedef struct packed {
		tag_t        tag;
		divsqrt_op_t op;
		word_t       a;
		word_t       b;
	} core_req_t;

endpackage

`default_nettype wire

/* cdb_pkg.sv */
`default_nettype none

`include "rs_settings.svh"

package cdb_pkg;

	typedef logic [`RS_ROB_WIDTH-1:0] tag_t;
	typedef logic [`RS_DATA_WIDTH-1:0] word_t;

	// broadcast bus, also used for a register read where valid means the value is present.
	typedef struct packed {
		logic  valid;
		tag_t  tag;
		word_t data;
	} cdb_t;

	typedef struct packed {
		tag_t  tag;
		word_t data;
	} result_t;

	function automatic logic tag_match(input cdb_t bus, input tag_t tag);
		return bus.valid && (bus.tag == tag);
	endfunction

endpackage

`default_nettype wire

/* rs_settings.svh */
`ifndef RS_SETTINGS_SVH
`define RS_SETTINGS_SVH

// reorder buffer tag width.
`define RS_ROB_WIDTH 6

// operand and result width.
`define RS_DATA_WIDTH 32

// station and core pairs in the cluster.
`define RS_N_UNITS 2

// entries per reservation station.
`define RS_N_ENTRY 2

`endif
